//--- fp_vec.f
src/fp_vec_pkg.sv
src/fp_lane_if.sv
src/fp_issue.sv
src/fp_lane.sv
src/fp_collect.sv
src/fp_vec_unit.sv
dv/fp_vec_chk.sv
dv/fp_vec_tb.sv

//--- dv/fp_vec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fp_vec_tb;

	localparam int NUM_LANES    = 4;
	localparam int W            = fp_vec_pkg::FP_W;
	localparam int DONE_TIMEOUT = 20; // cycles

	logic                   clk;
	logic                   rst_n;
	logic                   start;
	fp_vec_pkg::fp_op_e     op;
	logic [NUM_LANES*W-1:0] a_flat;
	logic [NUM_LANES*W-1:0] b_flat;
	logic                   done;
	logic [NUM_LANES*W-1:0] result_flat;
	logic [NUM_LANES-1:0]   ovf;
	logic [NUM_LANES-1:0]   unf;

	logic [31:0] lfsr = 32'h392a5ad1;
	int          errors = 0;
	int          test_err0 = 0; // error count when the current test began
	int          tests_run = 0;
	int          tests_failed = 0;
	int          cyc = 0;
	int          n_done = 0;
	int          issued_at [$]; // start cycles still waiting for done
	int          t0;

	fp_vec_unit #(.NUM_LANES(NUM_LANES)) dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.op          (op),
		.a_flat      (a_flat),
		.b_flat      (b_flat),
		.done        (done),
		.result_flat (result_flat),
		.ovf         (ovf),
		.unf         (unf)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r    = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return r;
	endfunction

	// latency and reset monitor sampled on each edge
	always @(posedge clk) begin
		cyc++;
		if (!rst_n && cyc >= 2 && (done !== 1'b0 || ovf !== '0 || unf !== '0)) begin
			errors++;
			$display("t=%0t done, ovf or unf active during reset", $time);
		end
		if (done === 1'b1) begin
			n_done++;
			if (issued_at.size() == 0) begin
				errors++;
				$display("t=%0t done pulse with no start outstanding", $time);
			end else begin
				t0 = issued_at.pop_front();
				if (cyc - t0 != 4) begin
					errors++;
					$display("FAILED t=%0t done latency: expected 4, got %0d", $time, cyc - t0);
				end
			end
		end
		if (rst_n && start)
			issued_at.push_back(cyc);
	end

	task automatic issue(input fp_vec_pkg::fp_op_e o, input logic [NUM_LANES*W-1:0] a,
		input logic [NUM_LANES*W-1:0] b);
		@(posedge clk);
		#1;
		start  = 1'b1;
		op     = o;
		a_flat = a;
		b_flat = b;
		@(posedge clk);
		#1;
		start = 1'b0;
	endtask

	task automatic wait_done(input string what);
		int k;
		k = 0;
		while (done !== 1'b1 && k < DONE_TIMEOUT) begin
			@(posedge clk);
			#1;
			k++;
		end
		if (done !== 1'b1) begin
			errors++;
			$display("timeout, no done pulse for %s", what);
		end
	endtask

	task automatic check_lane(input int l, input logic [W-1:0] er, input logic eo, input logic eu);
		if (result_flat[l*W +: W] !== er) begin
			errors++;
			$display("FAILED t=%0t result_flat[%0d]: expected %h, got %h",
				$time, l, er, result_flat[l*W +: W]);
		end
		if (ovf[l] !== eo || unf[l] !== eu) begin
			errors++;
			$display("FAILED t=%0t ovf/unf[%0d]: expected %b%b, got %b%b",
				$time, l, eo, eu, ovf[l], unf[l]);
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != test_err0)
			tests_failed++;
		$display("test %-10s %0d error(s)", name, errors - test_err0);
		test_err0 = errors;
	endtask

	task automatic run_burst(input int n);
		int done0;
		int k;
		done0 = n_done;
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			#1;
			start = 1'b1; // a new op every cycle
			op    = fp_vec_pkg::fp_op_e'(rand_bits(2));
			for (int l = 0; l < NUM_LANES; l++) begin
				a_flat[l*W +: W] = rand_bits(32);
				b_flat[l*W +: W] = rand_bits(32);
			end
		end
		@(posedge clk);
		#1;
		start = 1'b0;
		k = 0;
		while (n_done - done0 < n && k < DONE_TIMEOUT) begin
			@(posedge clk);
			#1;
			k++;
		end
		if (n_done - done0 != n) begin
			errors++;
			$display("burst of %0d starts gave %0d done pulses", n, n_done - done0);
		end
	endtask

	initial begin
		logic [NUM_LANES*W-1:0] ra;
		start  = 1'b0;
		op     = fp_vec_pkg::OP_MUL;
		a_flat = '0;
		b_flat = '0;
		rst_n  = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		end_test("reset");

		// 3.0*2.5, -2.0*0.5, denormal*1.0, 2^100*2^100
		issue(fp_vec_pkg::OP_MUL, {32'h71800000, 32'h00400000, 32'hC0000000, 32'h40400000},
			{32'h71800000, 32'h3F800000, 32'h3F000000, 32'h40200000});
		wait_done("multiply");
		check_lane(0, 32'h40F00000, 1'b0, 1'b0);
		check_lane(1, 32'hBF800000, 1'b0, 1'b0);
		check_lane(2, 32'h00000000, 1'b0, 1'b0);
		check_lane(3, 32'h7F800000, 1'b1, 1'b0);
		// -2^-100*2^-100, 1.0*1.0, 1.5*1.5, 0*2.0
		issue(fp_vec_pkg::OP_MUL, {32'h00000000, 32'h3FC00000, 32'h3F800000, 32'h8D800000},
			{32'h40000000, 32'h3FC00000, 32'h3F800000, 32'h0D800000});
		wait_done("multiply");
		check_lane(0, 32'h80000000, 1'b0, 1'b1);
		check_lane(1, 32'h3F800000, 1'b0, 1'b0);
		check_lane(2, 32'h40100000, 1'b0, 1'b0);
		check_lane(3, 32'h00000000, 1'b0, 1'b0);
		end_test("mul");

		issue(fp_vec_pkg::OP_ITOF, {32'h01000001, 32'd7, 32'd1, 32'd0}, {NUM_LANES{32'hFFFF}});
		wait_done("itof");
		check_lane(0, 32'h00000000, 1'b0, 1'b0);
		check_lane(1, 32'h3F800000, 1'b0, 1'b0);
		check_lane(2, 32'h40E00000, 1'b0, 1'b0);
		check_lane(3, 32'h4B800000, 1'b0, 1'b0); // low bit truncated away
		end_test("itof");

		// 2.5, -2.5, 0.25, -0.25
		issue(fp_vec_pkg::OP_FLOOR, {32'hBE800000, 32'h3E800000, 32'hC0200000, 32'h40200000}, '0);
		wait_done("floor");
		check_lane(0, 32'd2, 1'b0, 1'b0);
		check_lane(1, 32'hFFFFFFFD, 1'b0, 1'b0);
		check_lane(2, 32'd0, 1'b0, 1'b0);
		check_lane(3, 32'hFFFFFFFF, 1'b0, 1'b0);
		// 2^31, -2^31, 1.0, -1.0
		issue(fp_vec_pkg::OP_FLOOR, {32'hBF800000, 32'h3F800000, 32'hCF000000, 32'h4F000000}, '0);
		wait_done("floor");
		check_lane(0, 32'h7FFFFFFF, 1'b1, 1'b0);
		check_lane(1, 32'h80000000, 1'b1, 1'b0);
		check_lane(2, 32'd1, 1'b0, 1'b0);
		check_lane(3, 32'hFFFFFFFF, 1'b0, 1'b0);
		end_test("floor");

		ra[W-1:0] = 32'h40800000; // 4.0
		for (int l = 1; l < NUM_LANES; l++)
			ra[l*W +: W] = rand_bits(31); // sign bit stays clear
		issue(fp_vec_pkg::OP_RSQRT_EST, ra, '0);
		wait_done("rsqrt");
		check_lane(0, 32'h3EF75A86, 1'b0, 1'b0);
		for (int l = 1; l < NUM_LANES; l++)
			check_lane(l, fp_vec_pkg::RSQRT_MAGIC - (ra[l*W +: W] >> 1), 1'b0, 1'b0);
		end_test("rsqrt");

		run_burst(24);
		repeat (4) @(posedge clk); // catch any stray done
		#1;
		end_test("burst");

		errors = errors + int'(dut.u_chk.fail_count);
		$display("tests %0d, failed %0d, assertion failures %0d, errors %0d",
			tests_run, tests_failed, dut.u_chk.fail_count, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/fp_vec_chk.sv
`timescale 1ns/1ps
`default_nettype none

module fp_vec_chk #(
	parameter int NUM_LANES = 4
) (
	input logic                                  clk,
	input logic                                  rst_n,
	input logic                                  start,
	input fp_vec_pkg::fp_op_e                    op,
	input logic [NUM_LANES*fp_vec_pkg::FP_W-1:0] a_flat,
	input logic [NUM_LANES*fp_vec_pkg::FP_W-1:0] b_flat,
	input logic                                  done,
	input logic [NUM_LANES*fp_vec_pkg::FP_W-1:0] result_flat,
	input logic [NUM_LANES-1:0]                  ovf,
	input logic [NUM_LANES-1:0]                  unf
);

	localparam int W = fp_vec_pkg::FP_W;

	// four deep request history, index 3 lines up with done
	logic                   st_h [4];
	fp_vec_pkg::fp_op_e     op_h [4];
	logic [NUM_LANES*W-1:0] a_h  [4];
	logic [NUM_LANES*W-1:0] b_h  [4];
	int unsigned            fail_count = 0; // read by the testbench at the end

	always_ff @(posedge clk) begin
		st_h[0] <= rst_n && start;
		op_h[0] <= op;
		a_h[0]  <= a_flat;
		b_h[0]  <= b_flat;
		for (int k = 1; k < 4; k++) begin
			st_h[k] <= rst_n && st_h[k-1]; // history cleared by reset
			op_h[k] <= op_h[k-1];
			a_h[k]  <= a_h[k-1];
			b_h[k]  <= b_h[k-1];
		end
	end

	// reference lane, returns {ovf, unf, result}
	function automatic logic [W+1:0] ref_lane(input fp_vec_pkg::fp_op_e o,
		input logic [W-1:0] a, input logic [W-1:0] b);
		int          ea;
		int          eb;
		int          e;
		int          k;
		logic [47:0] prod;
		logic [54:0] sh;
		logic [63:0] fx; // 32.32 fixed point
		logic [31:0] ip;
		logic        sg;
		ea = int'(a[30:23]);
		eb = int'(b[30:23]);
		sg = a[31];
		case (o)
			fp_vec_pkg::OP_MUL: begin
				if (ea == 0 || eb == 0)
					return '0; // denormal or zero flushes to +0
				sg   = a[31] ^ b[31];
				prod = 48'({1'b1, a[22:0]}) * 48'({1'b1, b[22:0]});
				e    = prod[47] ? ea + eb - 126 : ea + eb - 127;
				if (e >= 255)
					return {2'b10, sg, 8'hFF, 23'h0};
				if (e <= 0)
					return {2'b01, sg, 31'h0};
				return {2'b00, sg, 8'(e), prod[47] ? prod[46:24] : prod[45:23]};
			end
			fp_vec_pkg::OP_ITOF: begin
				if (a == '0)
					return '0;
				k = 31;
				while (!a[k])
					k--; // walk down to the leading one
				sh = {a, 23'h0} >> k; // bits under the leading one land in [22:0]
				return {2'b00, 1'b0, 8'(127 + k), sh[22:0]};
			end
			fp_vec_pkg::OP_FLOOR: begin
				if (ea >= 158)
					return {2'b10, sg ? 32'h80000000 : 32'h7FFFFFFF};
				if (ea < 127)
					return {2'b00, (sg && a[30:0] != '0) ? 32'hFFFFFFFF : 32'h0};
				fx = 64'({1'b1, a[22:0]}) << (ea - 118);
				ip = fx[63:32];
				if (!sg)
					return {2'b00, ip};
				return {2'b00, 32'(32'd0 - ip - 32'(fx[31:0] != '0))}; // toward -inf
			end
			default: return {2'b00, 32'(fp_vec_pkg::RSQRT_MAGIC - (a[30:0] >> 1))};
		endcase
	endfunction

	logic [NUM_LANES*W-1:0] exp_result;
	logic [NUM_LANES-1:0]   exp_ovf;
	logic [NUM_LANES-1:0]   exp_unf;

	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			{exp_ovf[l], exp_unf[l], exp_result[l*W +: W]} =
				ref_lane(op_h[3], a_h[3][l*W +: W], b_h[3][l*W +: W]);
		end
	end

	a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> ##4 done)
		else begin $error("done missing 4 cycles after start"); fail_count++; end

	a_done_matched: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> st_h[3])
		else begin $error("done without a matching start"); fail_count++; end

	a_values: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> (result_flat == exp_result) && (ovf == exp_ovf) && (unf == exp_unf))
		else begin $error("lane outputs differ from reference"); fail_count++; end

	a_flags_excl: assert property (@(posedge clk) disable iff (!rst_n)
		(ovf & unf) == '0)
		else begin $error("ovf and unf both set in a lane"); fail_count++; end

endmodule

bind fp_vec_unit fp_vec_chk #(
	.NUM_LANES (NUM_LANES)
) u_chk (
	.clk         (clk),
	.rst_n       (rst_n),
	.start       (start),
	.op          (op),
	.a_flat      (a_flat),
	.b_flat      (b_flat),
	.done        (done),
	.result_flat (result_flat),
	.ovf         (ovf),
	.unf         (unf)
);

`default_nettype wire

//--- src/fp_vec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fp_vec_unit #(
	parameter int NUM_LANES = 4
) (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  start,
	input  fp_vec_pkg::fp_op_e                    op,
	input  logic [NUM_LANES*fp_vec_pkg::FP_W-1:0] a_flat,
	input  logic [NUM_LANES*fp_vec_pkg::FP_W-1:0] b_flat,
	output logic                                  done,
	output logic [NUM_LANES*fp_vec_pkg::FP_W-1:0] result_flat,
	output logic [NUM_LANES-1:0]                  ovf,
	output logic [NUM_LANES-1:0]                  unf
);

	// one request and one result channel per lane
	fp_lane_req_if req_if [NUM_LANES-1:0] ();
	fp_lane_res_if res_if [NUM_LANES-1:0] ();

	// start -> request, one cycle
	fp_issue #(
		.NUM_LANES (NUM_LANES)
	) u_issue (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (start),
		.op     (op),
		.a_flat (a_flat),
		.b_flat (b_flat),
		.req    (req_if)
	);

	// two stage datapath per lane
	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		fp_lane u_lane (
			.clk   (clk),
			.rst_n (rst_n),
			.req   (req_if[i]),
			.res   (res_if[i])
		);
	end

	// lane results -> done, one cycle
	fp_collect #(
		.NUM_LANES (NUM_LANES)
	) u_collect (
		.clk         (clk),
		.rst_n       (rst_n),
		.res         (res_if),
		.done        (done),
		.result_flat (result_flat),
		.ovf         (ovf),
		.unf         (unf)
	);

endmodule

`default_nettype wire

//--- src/fp_collect.sv
`timescale 1ns/1ps
`default_nettype none

module fp_collect #(
	parameter int NUM_LANES = 4
) (
	input  logic                                  clk,
	input  logic                                  rst_n,
	fp_lane_res_if.dst                            res [NUM_LANES-1:0],
	output logic                                  done,
	output logic [NUM_LANES*fp_vec_pkg::FP_W-1:0] result_flat,
	output logic [NUM_LANES-1:0]                  ovf,
	output logic [NUM_LANES-1:0]                  unf
);

	localparam int W = fp_vec_pkg::FP_W;

	logic                         lane0_valid; // lanes run in lockstep
	logic [NUM_LANES*W-1:0]       lane_result;
	logic [NUM_LANES-1:0]         lane_ovf;
	logic [NUM_LANES-1:0]         lane_unf;

	assign lane0_valid = res[0].valid;

	// flatten the interface array
	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		assign lane_result[i*W +: W] = res[i].result;
		assign lane_ovf[i]           = res[i].ovf;
		assign lane_unf[i]           = res[i].unf;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			done <= 1'b0;
			ovf  <= '0;
			unf  <= '0;
		end else begin
			done <= lane0_valid; // one pulse per item
			if (lane0_valid) begin
				ovf <= lane_ovf;
				unf <= lane_unf;
			end
		end
	end

	// result word holds between done pulses
	always_ff @(posedge clk) begin
		if (lane0_valid) begin
			result_flat <= lane_result;
		end
	end

endmodule

`default_nettype wire

//--- src/fp_lane.sv
`timescale 1ns/1ps
`default_nettype none

module fp_lane (
	input  logic       clk,
	input  logic       rst_n,
	fp_lane_req_if.dst req,
	fp_lane_res_if.src res
);

	localparam int W = fp_vec_pkg::FP_W;
	localparam int FLOOR_PIVOT = fp_vec_pkg::EXP_BIAS + 23; // lsb weight is one here
	localparam int FLOOR_SAT   = fp_vec_pkg::EXP_BIAS + 31; // |x| >= 2^31

	// operand fields
	logic       a_sign, b_sign;
	logic [7:0] a_exp, b_exp;
	logic [23:0] a_sig, b_sig; // hidden bit always set, denormals go through zero path

	assign a_sign = req.a[31];
	assign b_sign = req.b[31];
	assign a_exp  = req.a[30:23];
	assign b_exp  = req.b[30:23];
	assign a_sig  = {1'b1, req.a[22:0]};
	assign b_sig  = {1'b1, req.b[22:0]};

	logic [4:0] lead_idx; // leading one of the integer operand

	always_comb begin
		lead_idx = '0;
		for (int i = 0; i < W; i++) begin
			if (req.a[i]) lead_idx = 5'(i); // highest set bit wins
		end
	end

	// stage 1 next values
	logic              n_sign, n_zero, n_small, n_sat, n_nz, n_left;
	logic signed [9:0] n_exp;
	logic [47:0]       n_prod;
	logic [W-1:0]      n_word;
	logic [4:0]        n_shift;

	always_comb begin
		n_sign  = 1'b0;
		n_zero  = 1'b0;
		n_small = 1'b0;
		n_sat   = 1'b0;
		n_nz    = 1'b0;
		n_left  = 1'b0;
		n_exp   = '0;
		n_prod  = '0;
		n_word  = '0;
		n_shift = '0;
		case (req.op)
			fp_vec_pkg::OP_MUL: begin
				n_sign = a_sign ^ b_sign;
				n_zero = (a_exp == 8'd0) || (b_exp == 8'd0); // flush to zero
				n_prod = a_sig * b_sig;                      // full 24x24 product
				// biased sum, normalization adds one more in stage 2
				n_exp  = $signed({2'b00, a_exp}) + $signed({2'b00, b_exp})
					- 10'(fp_vec_pkg::EXP_BIAS);
			end
			fp_vec_pkg::OP_ITOF: begin
				n_zero = (req.a == '0);
				n_word = req.a;
				n_exp  = $signed({5'b00000, lead_idx});
			end
			fp_vec_pkg::OP_FLOOR: begin
				n_sign  = a_sign;
				n_nz    = (req.a[30:0] != 31'd0);
				n_small = (a_exp < 8'(fp_vec_pkg::EXP_BIAS)); // |x| < 1
				n_sat   = (a_exp >= 8'(FLOOR_SAT));
				n_left  = (a_exp >= 8'(FLOOR_PIVOT));
				n_shift = n_left ? 5'(a_exp - FLOOR_PIVOT) : 5'(FLOOR_PIVOT - a_exp);
				n_word  = {8'h00, a_sig};
			end
			fp_vec_pkg::OP_RSQRT_EST: begin
				// seed only, sign dropped before the shift
				n_word = fp_vec_pkg::RSQRT_MAGIC - ({1'b0, req.a[30:0]} >> 1);
			end
			default: ;
		endcase
	end

	// stage 1 registers
	logic               v1;
	fp_vec_pkg::fp_op_e s1_op;
	logic               s1_sign, s1_zero, s1_small, s1_sat, s1_nz, s1_left;
	logic signed [9:0]  s1_exp;
	logic [47:0]        s1_prod;
	logic [W-1:0]       s1_word;
	logic [4:0]         s1_shift;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			v1 <= 1'b0;
		end else begin
			v1 <= req.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (req.valid) begin
			s1_op    <= req.op;
			s1_sign  <= n_sign;
			s1_zero  <= n_zero;
			s1_small <= n_small;
			s1_sat   <= n_sat;
			s1_nz    <= n_nz;
			s1_left  <= n_left;
			s1_exp   <= n_exp;
			s1_prod  <= n_prod;
			s1_word  <= n_word;
			s1_shift <= n_shift;
		end
	end

	// stage 2 normalize and pack
	logic signed [9:0] mul_exp;
	logic [22:0]       mul_mant;
	logic [W-1:0]      itof_norm, fl_mag;
	logic              fl_lost; // fraction bits shifted out
	logic [W-1:0]      nxt_result;
	logic              nxt_ovf, nxt_unf;

	assign mul_exp   = s1_exp + $signed({9'b0, s1_prod[47]});
	assign mul_mant  = s1_prod[47] ? s1_prod[46:24] : s1_prod[45:23];
	assign itof_norm = s1_word << (5'd31 - s1_exp[4:0]); // leading one to bit 31
	assign fl_mag    = s1_left ? (s1_word << s1_shift) : (s1_word >> s1_shift);
	assign fl_lost   = !s1_left && |(s1_word & ~({W{1'b1}} << s1_shift));

	always_comb begin
		nxt_result = '0;
		nxt_ovf    = 1'b0;
		nxt_unf    = 1'b0;
		case (s1_op)
			fp_vec_pkg::OP_MUL: begin
				if (s1_zero) begin
					nxt_result = '0; // +0, no flags
				end else if (mul_exp >= 10'sd255) begin
					nxt_ovf    = 1'b1;
					nxt_result = {s1_sign, 8'hFF, 23'd0};
				end else if (mul_exp <= 10'sd0) begin
					nxt_unf    = 1'b1;
					nxt_result = {s1_sign, 31'd0};
				end else begin
					nxt_result = {s1_sign, mul_exp[7:0], mul_mant};
				end
			end
			fp_vec_pkg::OP_ITOF: begin
				if (!s1_zero)
					nxt_result = {1'b0, 8'(fp_vec_pkg::EXP_BIAS) + {3'b000, s1_exp[4:0]},
						itof_norm[30:8]};
			end
			fp_vec_pkg::OP_FLOOR: begin
				if (s1_sat) begin
					nxt_ovf    = 1'b1;
					nxt_result = s1_sign ? 32'h80000000 : 32'h7FFFFFFF;
				end else if (s1_small) begin
					nxt_result = (s1_sign && s1_nz) ? 32'hFFFFFFFF : 32'h0;
				end else if (s1_sign) begin
					nxt_result = 32'd0 - (fl_mag + {31'd0, fl_lost}); // round down
				end else begin
					nxt_result = fl_mag;
				end
			end
			fp_vec_pkg::OP_RSQRT_EST: nxt_result = s1_word; // done in stage 1
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			res.valid <= 1'b0;
		end else begin
			res.valid <= v1;
		end
	end

	always_ff @(posedge clk) begin
		if (v1) begin
			res.result <= nxt_result;
			res.ovf    <= nxt_ovf;
			res.unf    <= nxt_unf;
		end
	end

endmodule

`default_nettype wire

//--- src/fp_issue.sv
`timescale 1ns/1ps
`default_nettype none

module fp_issue #(
	parameter int NUM_LANES = 4
) (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 start,
	input  fp_vec_pkg::fp_op_e                   op,
	input  logic [NUM_LANES*fp_vec_pkg::FP_W-1:0] a_flat,
	input  logic [NUM_LANES*fp_vec_pkg::FP_W-1:0] b_flat,
	fp_lane_req_if.src                           req [NUM_LANES-1:0]
);

	localparam int W = fp_vec_pkg::FP_W;

	logic               valid_q; // issue strobe, shared by all lanes
	fp_vec_pkg::fp_op_e op_q;
	logic               use_b;   // second operand live for this opcode

	// the only opcode decode in the unit
	assign use_b = (op == fp_vec_pkg::OP_MUL);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= start; // drops again when start is low
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			op_q <= op; // opcode held until next start
		end
	end

	// per lane operand slice
	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		logic [W-1:0] a_q;
		logic [W-1:0] b_q;

		always_ff @(posedge clk) begin
			if (start) begin
				a_q <= a_flat[i*W +: W];
				b_q <= use_b ? b_flat[i*W +: W] : '0; // unary ops see a clean b
			end
		end

		assign req[i].valid = valid_q;
		assign req[i].op    = op_q;
		assign req[i].a     = a_q;
		assign req[i].b     = b_q;
	end

endmodule

`default_nettype wire

//--- src/fp_lane_if.sv
`timescale 1ns/1ps
`default_nettype none

// request into one lane
interface fp_lane_req_if;

	logic                          valid; // one cycle pulse per item
	fp_vec_pkg::fp_op_e            op;
	logic [fp_vec_pkg::FP_W-1:0]   a;
	logic [fp_vec_pkg::FP_W-1:0]   b;     // zero unless multiply

	modport src (
		output valid, op, a, b
	);

	modport dst (
		input valid, op, a, b
	);

endinterface

// result out of one lane
interface fp_lane_res_if;

	logic                          valid;
	logic [fp_vec_pkg::FP_W-1:0]   result;
	logic                          ovf; // exponent or integer range exceeded
	logic                          unf; // multiply flushed to zero

	modport src (
		output valid, result, ovf, unf
	);

	modport dst (
		input valid, result, ovf, unf
	);

endinterface

`default_nettype wire

//--- src/fp_vec_pkg.sv
`default_nettype none

package fp_vec_pkg;

	// lane opcodes for the supported single precision blocks
	typedef enum logic [1:0] {
		OP_MUL       = 2'd0, // truncated significand product
		OP_ITOF      = 2'd1, // unsigned int to float
		OP_FLOOR     = 2'd2, // float to signed int toward -inf
		OP_RSQRT_EST = 2'd3  // magic number step only
	} fp_op_e;

	localparam int FP_W = 32; // ieee single word
	localparam int EXP_BIAS = 127;

	// magic constant for the inverse square root seed
	localparam logic [FP_W-1:0] RSQRT_MAGIC = 32'h5F375A86;

endpackage

`default_nettype wire
